// File: compile.f
logic/riscv_pkg.sv
logic/decode_pkg.sv
logic/opcode_decoder.sv
logic/funct_decoder.sv
logic/decode_merge.sv
logic/decode_stage.sv
dv/decode_stage_chk.sv
dv/decode_stage_tb.sv

// File: dv/decode_stage_chk.sv
module decode_stage_chk (
    input logic                 clk_i,
    input logic                 rst_n_i,
    input logic                 valid_i,
    input logic                 valid_o,
    input decode_pkg::decoded_t decoded_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // branches keep PC as operand a even when they never jump
    rd_zero_when_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o && !decoded_o.write_enable && !decoded_o.store_to_mem &&
        decoded_o.jump_kind == decode_pkg::BNONE &&
        decoded_o.rs1_or_pc == decode_pkg::RS1
        |-> decoded_o.addr_rd == '0)
    else $error("addr_rd is not zero for a non-writing instruction");

    rs1_zero_for_pc_operand: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o && decoded_o.rs1_or_pc == decode_pkg::PC &&
        decoded_o.jump_kind == decode_pkg::BNONE
        |-> decoded_o.addr_rs1 == '0)
    else $error("addr_rs1 is not zero while operand a is the pc");

    valid_pulse_follows_input: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o && $past(valid_o) |-> $past(valid_i, 1) && $past(valid_i, 2))
    else $error("valid_o stayed high without back to back input strobes");

endmodule

bind decode_merge decode_stage_chk chk_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .valid_i   (valid_i),
    .valid_o   (valid_o),
    .decoded_o (decoded_o)
);

// File: dv/decode_stage_tb.sv
module decode_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned SEED = 32'h761e_15c2;
    localparam int RANDOM_COUNT = 64;
    // tests take about 245 cycles (reset 10, alu 128, upper/mem 24, branch 18, random 65)
    localparam int MAX_CYCLES = 400;

    logic                 clk_i;
    logic                 rst_n_i;
    logic                 valid_i;
    riscv_pkg::word_t     pc_i;
    riscv_pkg::word_t     instr_i;
    logic                 valid_o;
    decode_pkg::decoded_t decoded_o;

    decode_pkg::decoded_t last_exp;
    int                   cycle_count = 0;

    decode_stage dut_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .valid_i   (valid_i),
        .pc_i      (pc_i),
        .instr_i   (instr_i),
        .valid_o   (valid_o),
        .decoded_o (decoded_o)
    );

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        end
    end

    task automatic compare_values(input logic [63:0] got, input logic [63:0] exp,
                                  input string what);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s, got %h expected %h", $time, what, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // RV32I alu operation from func3/func7 where is_r selects the strict R-type reading
    function automatic decode_pkg::alu_op_e expected_alu(input logic [2:0] f3,
            input logic [6:0] f7, input logic is_r, output logic legal);
        logic f7_zero;
        logic f7_alt;
        f7_zero = (f7 == 7'b0000000);
        f7_alt  = (f7 == 7'b0100000);
        legal   = !is_r || f7_zero;
        case (f3)
            3'b000: begin
                legal = !is_r || f7_zero || f7_alt;
                return (is_r && f7_alt) ? decode_pkg::SUB : decode_pkg::ADD;
            end
            3'b001: begin
                legal = f7_zero;
                return decode_pkg::SLL;
            end
            3'b010: return decode_pkg::SLT;
            3'b011: return decode_pkg::SLTU;
            3'b100: return decode_pkg::XOR;
            3'b101: begin
                legal = f7_zero || f7_alt;
                return f7_alt ? decode_pkg::SRA : decode_pkg::SRL;
            end
            3'b110: return decode_pkg::OR;
            default: return decode_pkg::AND;
        endcase
    endfunction

    function automatic decode_pkg::jump_kind_e expected_branch(input logic [2:0] f3);
        case (f3)
            3'b000: return decode_pkg::BEQ;
            3'b001: return decode_pkg::BNE;
            3'b100: return decode_pkg::BLT;
            3'b101: return decode_pkg::BGE;
            3'b110: return decode_pkg::BLTU;
            3'b111: return decode_pkg::BGEU;
            default: return decode_pkg::BNONE;
        endcase
    endfunction

    function automatic decode_pkg::decoded_t expected_decode(input riscv_pkg::word_t pc,
            input riscv_pkg::word_t instr);
        decode_pkg::decoded_t d;
        logic                 legal;
        logic                 use_rs1;
        logic                 use_rs2;
        d = '0;
        d.pc = pc;
        d.rs1_or_pc = decode_pkg::RS1;
        d.rs2_or_imm = decode_pkg::RS2;
        d.alu_op = decode_pkg::ADD;
        d.wb_origin = decode_pkg::ALU;
        d.jump_kind = decode_pkg::BNONE;
        legal = 1'b1;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (instr[6:0])
            riscv_pkg::OP_ALU_I: begin
                d.write_enable = 1'b1;
                d.rs2_or_imm = decode_pkg::IMM;
                d.alu_op = expected_alu(instr[14:12], instr[31:25], 1'b0, legal);
                use_rs1 = 1'b1;
            end
            riscv_pkg::OP_ALU: begin
                d.write_enable = 1'b1;
                d.alu_op = expected_alu(instr[14:12], instr[31:25], 1'b1, legal);
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            riscv_pkg::OP_LUI: begin
                d.write_enable = 1'b1;
                d.rs2_or_imm = decode_pkg::IMM;
            end
            riscv_pkg::OP_AUIPC: begin
                d.write_enable = 1'b1;
                d.rs1_or_pc = decode_pkg::PC;
                d.rs2_or_imm = decode_pkg::IMM;
            end
            riscv_pkg::OP_LW: begin
                d.write_enable = 1'b1;
                d.rs2_or_imm = decode_pkg::IMM;
                d.wb_origin = decode_pkg::MEM;
                use_rs1 = 1'b1;
            end
            riscv_pkg::OP_SW: begin
                d.rs2_or_imm = decode_pkg::IMM;
                d.store_to_mem = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            riscv_pkg::OP_BRANCH: begin
                d.rs1_or_pc = decode_pkg::PC;
                d.rs2_or_imm = decode_pkg::IMM;
                d.jump_kind = expected_branch(instr[14:12]);
                // a branch that never jumps reads no register
                use_rs1 = (d.jump_kind != decode_pkg::BNONE);
                use_rs2 = use_rs1;
            end
            riscv_pkg::OP_JAL: begin
                d.write_enable = 1'b1;
                d.rs1_or_pc = decode_pkg::PC;
                d.rs2_or_imm = decode_pkg::IMM;
                d.wb_origin = decode_pkg::PC_4;
                d.jump_kind = decode_pkg::JUMP;
            end
            default: legal = 1'b0;
        endcase
        d.addr_rs1 = use_rs1 ? instr[19:15] : 5'd0;
        d.addr_rs2 = use_rs2 ? instr[24:20] : 5'd0;
        d.addr_rd = instr[11:7];
        if (!legal) begin
            d = '0;
            d.pc = pc;
            d.rs1_or_pc = decode_pkg::RS1;
            d.rs2_or_imm = decode_pkg::RS2;
            d.alu_op = decode_pkg::ADD;
            d.wb_origin = decode_pkg::ALU;
            d.jump_kind = decode_pkg::BNONE;
        end
        return d;
    endfunction

    function automatic riscv_pkg::word_t build_instr(input logic [6:0] f7,
            input logic [2:0] f3, input logic [6:0] op);
        return {f7, 5'($urandom), 5'($urandom), f3, 5'($urandom), op};
    endfunction

    // mostly supported opcodes and some fully random words
    function automatic riscv_pkg::word_t random_instr();
        riscv_pkg::word_t w;
        int unsigned      pick;
        w = $urandom;
        pick = $urandom_range(9, 0);
        case (pick)
            0: w[6:0] = riscv_pkg::OP_ALU_I;
            1: w[6:0] = riscv_pkg::OP_ALU;
            2: w[6:0] = riscv_pkg::OP_LUI;
            3: w[6:0] = riscv_pkg::OP_AUIPC;
            4: w[6:0] = riscv_pkg::OP_LW;
            5: w[6:0] = riscv_pkg::OP_SW;
            6: w[6:0] = riscv_pkg::OP_BRANCH;
            7: w[6:0] = riscv_pkg::OP_JAL;
            default: w[6:0] = 7'($urandom);
        endcase
        return w;
    endfunction

    // one strobe, then the bundle must show up exactly one edge later
    task automatic decode_once(input riscv_pkg::word_t instr, input string what);
        decode_pkg::decoded_t exp;
        riscv_pkg::word_t     pc;
        pc = $urandom;
        exp = expected_decode(pc, instr);
        @(posedge clk_i);
        #2;
        compare_values(64'(valid_o), 64'd0, {what, ": valid_o without strobe"});
        compare_values(64'(decoded_o), 64'(last_exp), {what, ": bundle not held"});
        valid_i = 1'b1;
        pc_i = pc;
        instr_i = instr;
        @(posedge clk_i);
        #2;
        valid_i = 1'b0;
        compare_values(64'(valid_o), 64'd1, {what, ": valid_o"});
        compare_values(64'(decoded_o), 64'(exp), {what, ": decoded_o"});
        last_exp = exp;
    endtask

    task automatic after_reset();
        compare_values(64'(valid_o), 64'd0, "valid_o after reset");
        compare_values(64'(decoded_o), 64'd0, "decoded_o after reset");
        decode_once(build_instr(7'd0, 3'b000, riscv_pkg::OP_ALU_I), "first addi");
    endtask

    task automatic alu_encodings();
        logic [6:0] f7_set[4] = '{7'b0000000, 7'b0100000, 7'b0000001, 7'b1011010};
        logic [6:0] op;
        for (int k = 0; k < 2; k++) begin
            op = (k == 0) ? riscv_pkg::OP_ALU : riscv_pkg::OP_ALU_I;
            for (int f3 = 0; f3 < 8; f3++) begin
                for (int j = 0; j < 4; j++) begin
                    decode_once(build_instr(f7_set[j], 3'(f3), op),
                                $sformatf("op %b f3 %0d f7 %b", op, f3, f7_set[j]));
                    if (k == 0 && f7_set[j] == 7'b0000001) begin
                        compare_values(64'({decoded_o.write_enable, decoded_o.addr_rs1,
                                            decoded_o.addr_rs2, decoded_o.addr_rd}),
                                       64'd0, "mul encoding is not a nop");
                    end
                end
            end
        end
    endtask

    task automatic upper_and_memory();
        repeat (3) begin
            decode_once(build_instr(7'($urandom), 3'($urandom), riscv_pkg::OP_LUI), "lui");
            decode_once(build_instr(7'($urandom), 3'($urandom), riscv_pkg::OP_AUIPC), "auipc");
            decode_once(build_instr(7'($urandom), 3'b010, riscv_pkg::OP_LW), "lw");
            decode_once(build_instr(7'($urandom), 3'b010, riscv_pkg::OP_SW), "sw");
        end
    endtask

    task automatic branches_and_jal();
        for (int f3 = 0; f3 < 8; f3++) begin
            decode_once(build_instr(7'($urandom), 3'(f3), riscv_pkg::OP_BRANCH),
                        $sformatf("branch f3 %0d", f3));
        end
        decode_once(build_instr(7'($urandom), 3'($urandom), riscv_pkg::OP_JAL), "jal");
    endtask

    task automatic back_to_back_random(input int count);
        decode_pkg::decoded_t exp_q[$];
        decode_pkg::decoded_t exp;
        riscv_pkg::word_t     pc;
        riscv_pkg::word_t     instr;
        for (int i = 0; i <= count; i++) begin
            @(posedge clk_i);
            #2;
            if (i > 0) begin
                exp = exp_q.pop_front();
                compare_values(64'(valid_o), 64'd1, $sformatf("random %0d valid_o", i - 1));
                compare_values(64'(decoded_o), 64'(exp), $sformatf("random %0d bundle", i - 1));
                last_exp = exp;
            end
            if (i < count) begin
                pc = $urandom;
                instr = random_instr();
                exp_q.push_back(expected_decode(pc, instr));
                valid_i = 1'b1;
                pc_i = pc;
                instr_i = instr;
            end else begin
                valid_i = 1'b0;
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        clk_i = 1'b0;
        rst_n_i = 1'b0;
        valid_i = 1'b0;
        pc_i = '0;
        instr_i = '0;
        last_exp = '0;
        repeat (8) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        after_reset();
        alu_encodings();
        upper_and_memory();
        branches_and_jal();
        back_to_back_random(RANDOM_COUNT);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: logic/decode_merge.sv
module decode_merge (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      valid_i,
    input  riscv_pkg::word_t          pc_i,
    input  riscv_pkg::reg_addr_t      rs1_i,
    input  riscv_pkg::reg_addr_t      rs2_i,
    input  riscv_pkg::reg_addr_t      rd_i,
    input  decode_pkg::opcode_ctrl_t  op_ctrl_i,
    input  decode_pkg::funct_ctrl_t   fn_ctrl_i,
    output logic                      valid_o,
    output decode_pkg::decoded_t      decoded_o
);

    decode_pkg::alu_op_e    alu_op;
    decode_pkg::jump_kind_e jump_kind;
    logic                   legal;
    logic                   dead_branch;
    decode_pkg::decoded_t   decoded_d;

    // pick the function-field reading that matches the class
    always_comb begin
        alu_op    = op_ctrl_i.fixed_alu_op;
        legal     = 1'b1;
        jump_kind = decode_pkg::BNONE;
        case (op_ctrl_i.instr_class)
            decode_pkg::C_ALU: begin
                alu_op = fn_ctrl_i.alu_op_r;
                legal  = fn_ctrl_i.legal_r;
            end
            decode_pkg::C_ALU_I: begin
                alu_op = fn_ctrl_i.alu_op_i;
                legal  = fn_ctrl_i.legal_i;
            end
            decode_pkg::C_BRANCH: begin
                jump_kind = fn_ctrl_i.branch_kind;
            end
            decode_pkg::C_JAL: begin
                jump_kind = decode_pkg::JUMP;
            end
            decode_pkg::C_ILLEGAL: begin
                legal = 1'b0;
            end
            default: begin
                legal = 1'b1;
            end
        endcase
    end

    // branch with unknown func3 never jumps, so it reads nothing
    assign dead_branch = (op_ctrl_i.instr_class == decode_pkg::C_BRANCH) &&
                         !fn_ctrl_i.legal_branch;

    always_comb begin
        decoded_d.pc           = pc_i;
        decoded_d.write_enable = op_ctrl_i.write_enable;
        decoded_d.rs1_or_pc    = op_ctrl_i.rs1_or_pc;
        decoded_d.rs2_or_imm   = op_ctrl_i.rs2_or_imm;
        decoded_d.alu_op       = alu_op;
        decoded_d.wb_origin    = op_ctrl_i.wb_origin;
        decoded_d.store_to_mem = op_ctrl_i.store_to_mem;
        decoded_d.jump_kind    = jump_kind;
        decoded_d.addr_rd      = rd_i;

        // unread sources go to x0 so hazard logic sees no dependency
        decoded_d.addr_rs1 = (op_ctrl_i.reads_rs1 && !dead_branch) ? rs1_i : '0;
        decoded_d.addr_rs2 = (op_ctrl_i.reads_rs2 && !dead_branch) ? rs2_i : '0;

        // illegal instruction turns into x0 + x0 without write
        if (!legal) begin
            decoded_d.write_enable = 1'b0;
            decoded_d.rs1_or_pc    = decode_pkg::RS1;
            decoded_d.rs2_or_imm   = decode_pkg::RS2;
            decoded_d.alu_op       = decode_pkg::ADD;
            decoded_d.wb_origin    = decode_pkg::ALU;
            decoded_d.store_to_mem = 1'b0;
            decoded_d.jump_kind    = decode_pkg::BNONE;
            decoded_d.addr_rs1     = '0;
            decoded_d.addr_rs2     = '0;
            decoded_d.addr_rd      = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o   <= 1'b0;
            decoded_o <= '0;
        end else begin
            valid_o <= valid_i;
            // bundle holds until the next strobe
            if (valid_i) begin
                decoded_o <= decoded_d;
            end
        end
    end

endmodule

// File: logic/decode_pkg.sv
package decode_pkg;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU,
        XOR, SRL, SRA, OR, AND
    } alu_op_e;

    typedef enum logic {RS1, PC} src_a_e;

    typedef enum logic {RS2, IMM} src_b_e;

    typedef enum logic [1:0] {ALU, MEM, PC_4} wb_origin_e;

    typedef enum logic [2:0] {
        BNONE, JUMP, BEQ, BNE,
        BLT, BGE, BLTU, BGEU
    } jump_kind_e;

    typedef enum logic [3:0] {
        C_ALU_I, C_ALU, C_LUI, C_AUIPC, C_LW,
        C_SW, C_BRANCH, C_JAL, C_ILLEGAL
    } instr_class_e;

    // result of the opcode decoder
    typedef struct packed {
        instr_class_e instr_class;
        logic         write_enable;
        src_a_e       rs1_or_pc;
        src_b_e       rs2_or_imm;
        wb_origin_e   wb_origin;
        logic         store_to_mem;
        logic         reads_rs1;
        logic         reads_rs2;
        alu_op_e      fixed_alu_op;
    } opcode_ctrl_t;

    // result of the function-field decoder, both readings side by side
    typedef struct packed {
        alu_op_e    alu_op_r;
        alu_op_e    alu_op_i;
        logic       legal_r;
        logic       legal_i;
        jump_kind_e branch_kind;
        logic       legal_branch;
    } funct_ctrl_t;

    typedef struct packed {
        riscv_pkg::word_t     pc;
        logic                 write_enable;
        src_a_e               rs1_or_pc;
        src_b_e               rs2_or_imm;
        alu_op_e              alu_op;
        wb_origin_e           wb_origin;
        logic                 store_to_mem;
        jump_kind_e           jump_kind;
        riscv_pkg::reg_addr_t addr_rs1;
        riscv_pkg::reg_addr_t addr_rs2;
        riscv_pkg::reg_addr_t addr_rd;
    } decoded_t;

endpackage

// File: logic/decode_stage.sv
module decode_stage (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  valid_i,
    input  riscv_pkg::word_t      pc_i,
    input  riscv_pkg::word_t      instr_i,
    output logic                  valid_o,
    output decode_pkg::decoded_t  decoded_o
);

    decode_pkg::opcode_ctrl_t op_ctrl;
    decode_pkg::funct_ctrl_t  fn_ctrl;

    // opcode and function fields are decoded side by side
    opcode_decoder u_opcode_decoder (
        .opcode_i (instr_i[riscv_pkg::OPCODE_LSB +: $bits(riscv_pkg::opcode_t)]),
        .ctrl_o   (op_ctrl)
    );

    funct_decoder u_funct_decoder (
        .funct3_i (instr_i[riscv_pkg::FUNCT3_LSB +: $bits(riscv_pkg::funct3_t)]),
        .funct7_i (instr_i[riscv_pkg::FUNCT7_LSB +: $bits(riscv_pkg::funct7_t)]),
        .ctrl_o   (fn_ctrl)
    );

    decode_merge u_decode_merge (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .valid_i   (valid_i),
        .pc_i      (pc_i),
        .rs1_i     (instr_i[riscv_pkg::RS1_LSB +: $bits(riscv_pkg::reg_addr_t)]),
        .rs2_i     (instr_i[riscv_pkg::RS2_LSB +: $bits(riscv_pkg::reg_addr_t)]),
        .rd_i      (instr_i[riscv_pkg::RD_LSB +: $bits(riscv_pkg::reg_addr_t)]),
        .op_ctrl_i (op_ctrl),
        .fn_ctrl_i (fn_ctrl),
        .valid_o   (valid_o),
        .decoded_o (decoded_o)
    );

endmodule

// File: logic/funct_decoder.sv
module funct_decoder (
    input  riscv_pkg::funct3_t       funct3_i,
    input  riscv_pkg::funct7_t       funct7_i,
    output decode_pkg::funct_ctrl_t  ctrl_o
);

    decode_pkg::alu_op_e    base_op;
    decode_pkg::alu_op_e    alt_op;
    logic                   has_alt;
    logic                   is_shift;
    logic                   f7_normal;
    logic                   f7_modified;
    decode_pkg::jump_kind_e branch_kind;
    logic                   legal_branch;

    assign f7_normal   = (funct7_i == riscv_pkg::F7_ALU_NORMAL);
    assign f7_modified = (funct7_i == riscv_pkg::F7_ALU_MODIFIED);

    // operation under normal func7, plus the modified form where one exists
    always_comb begin
        base_op  = decode_pkg::ADD;
        alt_op   = decode_pkg::ADD;
        has_alt  = 1'b0;
        is_shift = 1'b0;
        case (funct3_i)
            riscv_pkg::F3_ADD_SUB: begin
                alt_op  = decode_pkg::SUB;
                has_alt = 1'b1;
            end
            riscv_pkg::F3_SLL: begin
                base_op  = decode_pkg::SLL;
                is_shift = 1'b1;
            end
            riscv_pkg::F3_SLT: begin
                base_op = decode_pkg::SLT;
            end
            riscv_pkg::F3_SLTU: begin
                base_op = decode_pkg::SLTU;
            end
            riscv_pkg::F3_XOR: begin
                base_op = decode_pkg::XOR;
            end
            riscv_pkg::F3_SRL_SRA: begin
                base_op  = decode_pkg::SRL;
                alt_op   = decode_pkg::SRA;
                has_alt  = 1'b1;
                is_shift = 1'b1;
            end
            riscv_pkg::F3_OR: begin
                base_op = decode_pkg::OR;
            end
            default: begin
                base_op = decode_pkg::AND;
            end
        endcase
    end

    always_comb begin
        legal_branch = 1'b1;
        case (funct3_i)
            riscv_pkg::F3_BEQ:  branch_kind = decode_pkg::BEQ;
            riscv_pkg::F3_BNE:  branch_kind = decode_pkg::BNE;
            riscv_pkg::F3_BLT:  branch_kind = decode_pkg::BLT;
            riscv_pkg::F3_BGE:  branch_kind = decode_pkg::BGE;
            riscv_pkg::F3_BLTU: branch_kind = decode_pkg::BLTU;
            riscv_pkg::F3_BGEU: branch_kind = decode_pkg::BGEU;
            default: begin
                branch_kind  = decode_pkg::BNONE;
                legal_branch = 1'b0;
            end
        endcase
    end

    always_comb begin
        // R-type: func7 must be normal unless a modified form exists
        // (the MUL encoding lands here as illegal)
        ctrl_o.alu_op_r = (has_alt && f7_modified) ? alt_op : base_op;
        ctrl_o.legal_r  = f7_normal || (has_alt && f7_modified);

        // I-type: func7 belongs to the immediate except for shifts
        ctrl_o.alu_op_i = (is_shift && has_alt && f7_modified) ? alt_op : base_op;
        ctrl_o.legal_i  = !is_shift || f7_normal || (has_alt && f7_modified);

        ctrl_o.branch_kind  = branch_kind;
        ctrl_o.legal_branch = legal_branch;
    end

endmodule

// File: logic/opcode_decoder.sv
module opcode_decoder (
    input  riscv_pkg::opcode_t        opcode_i,
    output decode_pkg::opcode_ctrl_t  ctrl_o
);

    always_comb begin
        // unknown opcodes fall through as a non-writing x0 + x0
        ctrl_o.instr_class  = decode_pkg::C_ILLEGAL;
        ctrl_o.write_enable = 1'b0;
        ctrl_o.rs1_or_pc    = decode_pkg::RS1;
        ctrl_o.rs2_or_imm   = decode_pkg::RS2;
        ctrl_o.wb_origin    = decode_pkg::ALU;
        ctrl_o.store_to_mem = 1'b0;
        ctrl_o.reads_rs1    = 1'b0;
        ctrl_o.reads_rs2    = 1'b0;
        ctrl_o.fixed_alu_op = decode_pkg::ADD;

        case (opcode_i)
            riscv_pkg::OP_ALU_I: begin
                ctrl_o.instr_class  = decode_pkg::C_ALU_I;
                ctrl_o.write_enable = 1'b1;
                ctrl_o.rs2_or_imm   = decode_pkg::IMM;
                ctrl_o.reads_rs1    = 1'b1;
            end

            riscv_pkg::OP_ALU: begin
                ctrl_o.instr_class  = decode_pkg::C_ALU;
                ctrl_o.write_enable = 1'b1;
                ctrl_o.reads_rs1    = 1'b1;
                ctrl_o.reads_rs2    = 1'b1;
            end

            riscv_pkg::OP_LUI: begin
                // x0 + imm, rs1 field is part of the immediate
                ctrl_o.instr_class  = decode_pkg::C_LUI;
                ctrl_o.write_enable = 1'b1;
                ctrl_o.rs2_or_imm   = decode_pkg::IMM;
                ctrl_o.fixed_alu_op = decode_pkg::ADD;
            end

            riscv_pkg::OP_AUIPC: begin
                ctrl_o.instr_class  = decode_pkg::C_AUIPC;
                ctrl_o.write_enable = 1'b1;
                ctrl_o.rs1_or_pc    = decode_pkg::PC;
                ctrl_o.rs2_or_imm   = decode_pkg::IMM;
                ctrl_o.fixed_alu_op = decode_pkg::ADD;
            end

            riscv_pkg::OP_LW: begin
                ctrl_o.instr_class  = decode_pkg::C_LW;
                ctrl_o.write_enable = 1'b1;
                ctrl_o.rs2_or_imm   = decode_pkg::IMM;
                ctrl_o.wb_origin    = decode_pkg::MEM;
                ctrl_o.reads_rs1    = 1'b1;
                ctrl_o.fixed_alu_op = decode_pkg::ADD;
            end

            riscv_pkg::OP_SW: begin
                // address from rs1 + imm, data from rs2
                ctrl_o.instr_class  = decode_pkg::C_SW;
                ctrl_o.rs2_or_imm   = decode_pkg::IMM;
                ctrl_o.store_to_mem = 1'b1;
                ctrl_o.reads_rs1    = 1'b1;
                ctrl_o.reads_rs2    = 1'b1;
                ctrl_o.fixed_alu_op = decode_pkg::ADD;
            end

            riscv_pkg::OP_BRANCH: begin
                // alu computes the target, comparison uses rs1 and rs2
                ctrl_o.instr_class  = decode_pkg::C_BRANCH;
                ctrl_o.rs1_or_pc    = decode_pkg::PC;
                ctrl_o.rs2_or_imm   = decode_pkg::IMM;
                ctrl_o.reads_rs1    = 1'b1;
                ctrl_o.reads_rs2    = 1'b1;
                ctrl_o.fixed_alu_op = decode_pkg::ADD;
            end

            riscv_pkg::OP_JAL: begin
                ctrl_o.instr_class  = decode_pkg::C_JAL;
                ctrl_o.write_enable = 1'b1;
                ctrl_o.rs1_or_pc    = decode_pkg::PC;
                ctrl_o.rs2_or_imm   = decode_pkg::IMM;
                ctrl_o.wb_origin    = decode_pkg::PC_4;
                ctrl_o.fixed_alu_op = decode_pkg::ADD;
            end

            default: begin
                ctrl_o.instr_class = decode_pkg::C_ILLEGAL;
            end
        endcase
    end

endmodule

// File: logic/riscv_pkg.sv
package riscv_pkg;

    // plain vectors for the widths used across the decode stage
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // field positions inside an instruction word
    localparam int OPCODE_LSB = 0;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;

    // major opcodes
    localparam opcode_t OP_ALU_I  = 7'b0010011;
    localparam opcode_t OP_ALU    = 7'b0110011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_LW     = 7'b0000011;
    localparam opcode_t OP_SW     = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;

    // func3 for OP and OP-IMM
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // func3 for BRANCH
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // func7, modified selects SUB and SRA
    localparam funct7_t F7_ALU_NORMAL   = 7'b0000000;
    localparam funct7_t F7_ALU_MODIFIED = 7'b0100000;

endpackage

// File: run.sh
#!/usr/bin/env bash
# builds the decode stage testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f compile.f \
    --top-module decode_stage_tb \
    -o decode_stage_sim

./obj_dir/decode_stage_sim
